//--- flist.f
mips_pkg.sv
alu_decoder.sv
alu_core.sv
branch_judge.sv
exec_top.sv
exec_checker.sv
tb_exec.sv

//--- Makefile
.PHONY: run clean

obj_dir/Vtb_exec: flist.f $(shell cat flist.f)
	verilator --binary --timing --top-module tb_exec -f flist.f -o Vtb_exec

sim.log: obj_dir/Vtb_exec
	./obj_dir/Vtb_exec > sim.log

run: obj_dir/Vtb_exec
	./obj_dir/Vtb_exec | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_exec.sv
`timescale 1ns/1ps

module tb_exec;

	localparam int n_rand      = 200;
	localparam int period_ns   = 100;
	// six tests, each at most n_rand strobes plus drain, then a margin
	localparam int run_cycles  = 16 + 6 * (n_rand + 16);
	localparam int watchdog_ns = (run_cycles + 50) * period_ns;

	localparam logic [5:0] r_fns [22] = '{
		mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor,
		mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub, mips_pkg::fn_subu,
		mips_pkg::fn_slt, mips_pkg::fn_sltu, mips_pkg::fn_sll, mips_pkg::fn_srl,
		mips_pkg::fn_sra, mips_pkg::fn_sllv, mips_pkg::fn_srlv, mips_pkg::fn_srav,
		mips_pkg::fn_mthi, mips_pkg::fn_mtlo, mips_pkg::fn_mult, mips_pkg::fn_multu,
		mips_pkg::fn_div, mips_pkg::fn_divu
	};
	localparam logic [5:0] sp2_fns [7] = '{
		mips_pkg::fn2_clo, mips_pkg::fn2_clz, mips_pkg::fn2_mul, mips_pkg::fn2_madd,
		mips_pkg::fn2_maddu, mips_pkg::fn2_msub, mips_pkg::fn2_msubu
	};
	localparam logic [5:0] imm_ops [8] = '{
		mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
		mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui
	};
	localparam logic [5:0] trap_fns [6] = '{
		mips_pkg::fn_teq, mips_pkg::fn_tne, mips_pkg::fn_tge,
		mips_pkg::fn_tgeu, mips_pkg::fn_tlt, mips_pkg::fn_tltu
	};
	localparam logic [4:0] trap_rts [6] = '{
		mips_pkg::rt_teqi, mips_pkg::rt_tnei, mips_pkg::rt_tgei,
		mips_pkg::rt_tgeiu, mips_pkg::rt_tlti, mips_pkg::rt_tltiu
	};
	localparam logic [5:0] br_ops [4] = '{
		mips_pkg::op_beq, mips_pkg::op_bne, mips_pkg::op_bgtz, mips_pkg::op_blez
	};
	localparam logic [4:0] br_rts [4] = '{
		mips_pkg::rt_bltz, mips_pkg::rt_bgez, mips_pkg::rt_bltzal, mips_pkg::rt_bgezal
	};

	logic                clk;
	logic                reset;
	logic                in_valid;
	mips_pkg::exec_req_t req;
	logic                out_valid;
	mips_pkg::exec_rsp_t rsp;

	int err_count;
	int chk_count;
	int pending;
	int fail_count;
	int err_mark;
	int chk_mark;

	exec_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.rsp       (rsp)
	);

	exec_checker i_checker (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.rsp       (rsp),
		.err_count (err_count),
		.chk_count (chk_count),
		.pending   (pending)
	);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: run still busy after %0d ns", watchdog_ns);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [31:0] make_r(input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] sh);
		return {op, 5'($urandom), 5'($urandom), 5'($urandom), sh, fn};
	endfunction

	function automatic logic [31:0] make_i(input logic [5:0] op, input logic [4:0] rt,
			input logic [15:0] imm);
		return {op, 5'($urandom), rt, imm};
	endfunction

	// random value with a run of equal leading bits
	function automatic logic [31:0] lead_value();
		logic [31:0] v;
		v = $urandom >> ($urandom % 32);
		if ($urandom % 2 == 1)
			v = ~v;
		return v;
	endfunction

	task automatic send(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b);
		@(negedge clk);
		in_valid     = 1'b1;
		req.instr    = instr;
		req.rs_value = a;
		req.rt_value = b;
	endtask

	// idle cycles carry garbage on req
	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
			req      = {$urandom, $urandom, $urandom};
		end
	endtask

	task automatic mark_counts();
		err_mark = err_count;
		chk_mark = chk_count;
	endtask

	task automatic report_test(input string name);
		int waited;
		waited = 0;
		@(negedge clk);
		in_valid = 1'b0;
		@(posedge clk);
		while (pending != 0 && waited < 8) begin
			@(posedge clk);
			waited++;
		end
		if (pending != 0) begin
			$display("test %s: %0d responses never arrived", name, pending);
			fail_count++;
		end
		$display("test %s done: %0d responses, %0d errors", name,
			chk_count - chk_mark, err_count - err_mark);
	endtask

	task automatic handshake_seq();
		mark_counts();
		idle(4);
		send(make_r(mips_pkg::op_r_type, mips_pkg::fn_addu, 5'd0), 32'd5, 32'd7);
		idle(3);
		for (int i = 0; i < 6; i++)
			send(make_r(mips_pkg::op_r_type, mips_pkg::fn_add, 5'd0), $urandom, $urandom);
		idle(1);
		send(make_r(mips_pkg::op_r_type, mips_pkg::fn_xor, 5'd0), $urandom, $urandom);
		idle(2);
		send(make_r(mips_pkg::op_r_type, mips_pkg::fn_or, 5'd0), $urandom, $urandom);
		report_test("handshake");
		if (chk_count - chk_mark != 9) begin
			$display("handshake: 9 strobes sent but %0d responses seen", chk_count - chk_mark);
			fail_count++;
		end
	endtask

	task automatic random_rtype();
		logic [4:0]  k;
		logic [2:0]  j;
		logic [31:0] instr;
		mark_counts();
		send(make_r(mips_pkg::op_special2, mips_pkg::fn2_clz, 5'd0), 32'd0, $urandom);
		send(make_r(mips_pkg::op_special2, mips_pkg::fn2_clo, 5'd0), 32'hffff_ffff, $urandom);
		for (int i = 0; i < n_rand; i++) begin
			k = 5'($urandom % 22);
			j = 3'($urandom % 7);
			if ($urandom % 4 == 0)
				instr = make_r(mips_pkg::op_special2, sp2_fns[j], 5'($urandom));
			else
				instr = make_r(mips_pkg::op_r_type, r_fns[k], 5'($urandom));
			send(instr, lead_value(), $urandom);
		end
		report_test("rtype");
	endtask

	task automatic immediate_ops();
		logic [2:0] k;
		mark_counts();
		for (int i = 0; i < n_rand; i++) begin
			k = 3'($urandom);
			send(make_i(imm_ops[k], 5'($urandom), 16'($urandom)), lead_value(), $urandom);
		end
		report_test("immediate");
	endtask

	task automatic send_pair(input logic [5:0] fn_s, input logic [5:0] fn_u,
			input logic [31:0] a, input logic [31:0] b);
		send(make_r(mips_pkg::op_r_type, fn_s, 5'd0), a, b);
		send(make_r(mips_pkg::op_r_type, fn_u, 5'd0), a, b);
	endtask

	task automatic overflow_cases();
		mark_counts();
		send_pair(mips_pkg::fn_add, mips_pkg::fn_addu, 32'h7fff_ffff, 32'd1);
		send_pair(mips_pkg::fn_add, mips_pkg::fn_addu, 32'h8000_0000, 32'h8000_0000);
		send_pair(mips_pkg::fn_add, mips_pkg::fn_addu, 32'h8000_0000, 32'hffff_ffff);
		send_pair(mips_pkg::fn_add, mips_pkg::fn_addu, 32'h7fff_ffff, 32'hffff_ffff);
		send_pair(mips_pkg::fn_sub, mips_pkg::fn_subu, 32'h8000_0000, 32'd1);
		send_pair(mips_pkg::fn_sub, mips_pkg::fn_subu, 32'h7fff_ffff, 32'hffff_ffff);
		send_pair(mips_pkg::fn_sub, mips_pkg::fn_subu, 32'd0, 32'h8000_0000);
		send_pair(mips_pkg::fn_sub, mips_pkg::fn_subu, 32'hffff_ffff, 32'd1);
		send(make_i(mips_pkg::op_addi, 5'd1, 16'h0001), 32'h7fff_ffff, $urandom);
		send(make_i(mips_pkg::op_addiu, 5'd1, 16'h0001), 32'h7fff_ffff, $urandom);
		send(make_i(mips_pkg::op_addi, 5'd1, 16'hffff), 32'h8000_0000, $urandom);
		send(make_i(mips_pkg::op_addiu, 5'd1, 16'hffff), 32'h8000_0000, $urandom);
		send(make_i(mips_pkg::op_addi, 5'd1, 16'h7fff), 32'h7fff_0000, $urandom);
		report_test("overflow");
	endtask

	task automatic trap_cases();
		logic [31:0] a;
		logic [15:0] imm;
		logic [2:0]  k;
		mark_counts();
		for (int i = 0; i < n_rand; i++) begin
			a   = lead_value();
			imm = 16'($urandom);
			k   = 3'($urandom % 6);
			case ($urandom % 3)
				0: send(make_r(mips_pkg::op_r_type, trap_fns[k], 5'd0), a,
					($urandom % 3 == 0) ? a : $urandom);
				1: begin
					// now and then make rs equal to the extended immediate
					if ($urandom % 3 == 0)
						a = {{16{imm[15]}}, imm};
					send(make_i(mips_pkg::op_regimm, trap_rts[k], imm), a, $urandom);
				end
				default: send(make_i(mips_pkg::op_sc, 5'($urandom), imm), a, $urandom);
			endcase
		end
		report_test("trap");
	endtask

	task automatic branch_cases();
		logic [31:0] a;
		logic [31:0] instr;
		mark_counts();
		for (int i = 0; i < n_rand; i++) begin
			case ($urandom % 5)
				0: a = 32'd0;
				1: a = 32'h8000_0000;
				2: a = 32'hffff_ffff;
				3: a = 32'd1;
				default: a = $urandom;
			endcase
			case ($urandom % 4)
				0: instr = make_i(br_ops[2'($urandom)], 5'($urandom), 16'($urandom));
				1: instr = make_i(mips_pkg::op_regimm, br_rts[2'($urandom)], 16'($urandom));
				// loads and stores live at 10xxxx
				2: instr = make_i({2'b10, 4'($urandom)}, 5'($urandom), 16'($urandom));
				default: instr = $urandom;
			endcase
			send(instr, a, ($urandom % 2 == 0) ? a : $urandom);
		end
		report_test("branch");
	endtask

	initial begin
		void'($urandom(32'hf47));
		in_valid   = 1'b0;
		req        = '0;
		reset      = 1'b1;
		fail_count = 0;
		err_mark   = 0;
		chk_mark   = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		handshake_seq();
		random_rtype();
		immediate_ops();
		overflow_cases();
		trap_cases();
		branch_cases();

		$display("summary: %0d responses checked, %0d errors, %0d other failures",
			chk_count, err_count, fail_count);
		if (err_count == 0 && fail_count == 0 && chk_count > 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- exec_checker.sv
`timescale 1ns/1ps

module exec_checker (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  mips_pkg::exec_req_t req,
	input  logic                out_valid,
	input  mips_pkg::exec_rsp_t rsp,
	output int                  err_count,
	output int                  chk_count,
	output int                  pending
);

	mips_pkg::exec_req_t req_q [$];
	int                  cyc_q [$];

	int cycle    = 0;
	int accepted = 0;
	int retired  = 0;
	int errs     = 0;
	int checks   = 0;

	assign err_count = errs;
	assign chk_count = checks;
	assign pending   = accepted - retired;

	// length of the run of v from the msb down
	function automatic logic [31:0] run_length(input logic [31:0] x, input logic v);
		int n;
		n = 0;
		while (n < 32 && x[31 - n] == v)
			n++;
		return 32'(n);
	endfunction

	// 33-bit signed sum or difference, top two bits differ on overflow
	function automatic logic [32:0] wide_sum(input logic [31:0] x, input logic [31:0] y,
			input logic minus);
		logic [32:0] xe;
		logic [32:0] ye;
		xe = {x[31], x};
		ye = {y[31], y};
		if (minus)
			return xe - ye;
		return xe + ye;
	endfunction

	function automatic string rsp_text(input mips_pkg::exec_rsp_t x);
		return $sformatf("%h ov %b tr %b br %b", x.result, x.overflow, x.trap,
			x.branch_taken);
	endfunction

	function automatic mips_pkg::exec_rsp_t ref_exec(input mips_pkg::exec_req_t r);
		mips_pkg::exec_rsp_t e;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rt;
		logic [4:0]  sh;
		logic [31:0] s;
		logic [31:0] t;
		logic [31:0] se;
		logic [32:0] wide;
		op   = r.instr[31:26];
		fn   = r.instr[5:0];
		rt   = r.instr[20:16];
		sh   = r.instr[10:6];
		s    = r.rs_value;
		t    = r.rt_value;
		se   = {{16{r.instr[15]}}, r.instr[15:0]};
		wide = '0;
		e    = '0;
		case (op)
			mips_pkg::op_r_type: begin
				case (fn)
					mips_pkg::fn_and:  e.result = s & t;
					mips_pkg::fn_or:   e.result = s | t;
					mips_pkg::fn_xor:  e.result = s ^ t;
					mips_pkg::fn_nor:  e.result = ~(s | t);
					mips_pkg::fn_addu: e.result = s + t;
					mips_pkg::fn_subu: e.result = s - t;
					mips_pkg::fn_add, mips_pkg::fn_sub: begin
						wide       = wide_sum(s, t, fn == mips_pkg::fn_sub);
						e.result   = wide[31:0];
						e.overflow = wide[32] ^ wide[31];
					end
					mips_pkg::fn_slt:  e.result = {31'd0, $signed(s) < $signed(t)};
					mips_pkg::fn_sltu: e.result = {31'd0, s < t};
					mips_pkg::fn_sll:  e.result = t << sh;
					mips_pkg::fn_srl:  e.result = t >> sh;
					mips_pkg::fn_sra:  e.result = $signed(t) >>> sh;
					mips_pkg::fn_sllv: e.result = t << s[4:0];
					mips_pkg::fn_srlv: e.result = t >> s[4:0];
					mips_pkg::fn_srav: e.result = $signed(t) >>> s[4:0];
					mips_pkg::fn_mthi, mips_pkg::fn_mtlo: e.result = s;
					mips_pkg::fn_teq:  e.trap = (s == t);
					mips_pkg::fn_tne:  e.trap = (s != t);
					mips_pkg::fn_tge:  e.trap = ($signed(s) >= $signed(t));
					mips_pkg::fn_tgeu: e.trap = (s >= t);
					mips_pkg::fn_tlt:  e.trap = ($signed(s) < $signed(t));
					mips_pkg::fn_tltu: e.trap = (s < t);
					// mult/div and unknown functions give zero
					default: ;
				endcase
			end
			mips_pkg::op_addi: begin
				wide       = wide_sum(s, se, 1'b0);
				e.result   = wide[31:0];
				e.overflow = wide[32] ^ wide[31];
			end
			mips_pkg::op_addiu: e.result = s + se;
			mips_pkg::op_slti:  e.result = {31'd0, $signed(s) < $signed(se)};
			mips_pkg::op_sltiu: e.result = {31'd0, s < se};
			mips_pkg::op_andi:  e.result = s & {16'd0, r.instr[15:0]};
			mips_pkg::op_ori:   e.result = s | {16'd0, r.instr[15:0]};
			mips_pkg::op_xori:  e.result = s ^ {16'd0, r.instr[15:0]};
			mips_pkg::op_lui:   e.result = {r.instr[15:0], 16'd0};
			mips_pkg::op_sc:    e.result = 32'd1;
			mips_pkg::op_special2: begin
				if (fn == mips_pkg::fn2_clz)
					e.result = run_length(s, 1'b0);
				else if (fn == mips_pkg::fn2_clo)
					e.result = run_length(s, 1'b1);
			end
			mips_pkg::op_regimm: begin
				case (rt)
					mips_pkg::rt_bltz, mips_pkg::rt_bltzal: e.branch_taken = s[31];
					mips_pkg::rt_bgez, mips_pkg::rt_bgezal: e.branch_taken = !s[31];
					mips_pkg::rt_teqi:  e.trap = (s == se);
					mips_pkg::rt_tnei:  e.trap = (s != se);
					mips_pkg::rt_tgei:  e.trap = ($signed(s) >= $signed(se));
					mips_pkg::rt_tgeiu: e.trap = (s >= se);
					mips_pkg::rt_tlti:  e.trap = ($signed(s) < $signed(se));
					mips_pkg::rt_tltiu: e.trap = (s < se);
					default: ;
				endcase
			end
			mips_pkg::op_beq:  e.branch_taken = (s == t);
			mips_pkg::op_bne:  e.branch_taken = (s != t);
			mips_pkg::op_bgtz: e.branch_taken = ($signed(s) > 0);
			mips_pkg::op_blez: e.branch_taken = ($signed(s) <= 0);
			default: ;
		endcase
		return e;
	endfunction

	// inputs are stable at the rising edge
	always @(posedge clk) begin
		if (!reset && in_valid) begin
			// tag with the cycle that held the strobe
			req_q.push_back(req);
			cyc_q.push_back(cycle);
			accepted = accepted + 1;
		end
		cycle = cycle + 1;
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		mips_pkg::exec_rsp_t want;
		logic                due;
		due = (cyc_q.size() > 0) && (cyc_q[0] + 2 == cycle);
		if (due) begin
			want = ref_exec(req_q[0]);
			if (out_valid !== 1'b1) begin
				$display("missing response at %0t for instruction %h", $time, req_q[0].instr);
				errs++;
			end else begin
				checks++;
				if (rsp !== want) begin
					$display("ERR %0t: instr %h rs %h rt %h got %s, expected %s", $time,
						req_q[0].instr, req_q[0].rs_value, req_q[0].rt_value,
						rsp_text(rsp), rsp_text(want));
					errs++;
				end
			end
			void'(req_q.pop_front());
			void'(cyc_q.pop_front());
			retired++;
		end else if (out_valid !== 1'b0) begin
			$display("unexpected out_valid at %0t with no request due", $time);
			errs++;
		end
	end

endmodule

//--- exec_top.sv
`timescale 1ns/1ps

module exec_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  mips_pkg::exec_req_t req,
	output logic                out_valid,
	output mips_pkg::exec_rsp_t rsp
);

	mips_pkg::dec_ctl_t  dec_ctl;
	logic [31:0]         opnd_b;

	// stage 1
	logic                s1_valid;
	mips_pkg::dec_ctl_t  s1_ctl;
	logic [31:0]         s1_a;
	logic [31:0]         s1_b;
	logic [31:0]         s1_rt;

	mips_pkg::exec_rsp_t ex_rsp;

	alu_decoder i_decoder (
		.instr (req.instr),
		.ctl   (dec_ctl)
	);

	// operand b from rt or the immediate field
	always_comb begin
		case (dec_ctl.imm_kind)
			mips_pkg::imm_sign:  opnd_b = {{16{req.instr[15]}}, req.instr[15:0]};
			mips_pkg::imm_zero:  opnd_b = {16'd0, req.instr[15:0]};
			mips_pkg::imm_upper: opnd_b = {req.instr[15:0], 16'd0};
			default:             opnd_b = req.rt_value;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_ctl <= dec_ctl;
			s1_a   <= req.rs_value;
			s1_b   <= opnd_b;
			s1_rt  <= req.rt_value;
		end
	end

	alu_core i_alu (
		.alu_op   (s1_ctl.alu_op),
		.sa       (s1_ctl.sa),
		.a        (s1_a),
		.b        (s1_b),
		.result   (ex_rsp.result),
		.overflow (ex_rsp.overflow),
		.trap     (ex_rsp.trap)
	);

	branch_judge i_branch (
		.br_op    (s1_ctl.br_op),
		.rs_value (s1_a),
		.rt_value (s1_rt),
		.taken    (ex_rsp.branch_taken)
	);

	// stage 2
	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid)
			rsp <= ex_rsp;
	end

endmodule

//--- branch_judge.sv
`timescale 1ns/1ps

module branch_judge (
	input  mips_pkg::br_op_e br_op,
	input  logic [31:0]      rs_value,
	input  logic [31:0]      rt_value,
	output logic             taken
);

	logic rs_neg;
	logic rs_zero;

	assign rs_neg  = rs_value[31];
	assign rs_zero = (rs_value == 32'd0);

	always_comb begin
		case (br_op)
			mips_pkg::br_eq:  taken = (rs_value == rt_value);
			mips_pkg::br_neq: taken = (rs_value != rt_value);
			// signed compare against zero
			mips_pkg::br_gtz: taken = !rs_neg && !rs_zero;
			mips_pkg::br_lez: taken = rs_neg || rs_zero;
			mips_pkg::br_ltz: taken = rs_neg;
			mips_pkg::br_gez: taken = !rs_neg;
			default:          taken = 1'b0;
		endcase
	end

endmodule

//--- alu_core.sv
`timescale 1ns/1ps

module alu_core (
	input  mips_pkg::alu_op_e alu_op,
	input  logic [4:0]        sa,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	output logic [31:0]       result,
	output logic              overflow,
	output logic              trap
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        add_ovf;
	logic        sub_ovf;
	logic        lt_signed;
	logic        lt_unsigned;

	// number of leading zero bits
	function automatic logic [31:0] lead_zeros(input logic [31:0] x);
		logic [31:0] n;
		logic        seen;
		n = 32'd0;
		seen = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (x[i])
				seen = 1'b1;
			else if (!seen)
				n = n + 32'd1;
		end
		return n;
	endfunction

	assign sum  = a + b;
	assign diff = a - b;

	// operands agree in sign but the result does not
	assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
	assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		result   = 32'd0;
		overflow = 1'b0;
		trap     = 1'b0;
		case (alu_op)
			mips_pkg::alu_and:  result = a & b;
			mips_pkg::alu_or:   result = a | b;
			mips_pkg::alu_xor:  result = a ^ b;
			mips_pkg::alu_nor:  result = ~(a | b);
			mips_pkg::alu_add: begin
				result   = sum;
				overflow = add_ovf;
			end
			mips_pkg::alu_addu: result = sum;
			mips_pkg::alu_sub: begin
				result   = diff;
				overflow = sub_ovf;
			end
			mips_pkg::alu_subu: result = diff;
			mips_pkg::alu_slt:  result = {31'd0, lt_signed};
			mips_pkg::alu_sltu: result = {31'd0, lt_unsigned};

			// shift amount from the instruction
			mips_pkg::alu_sll_sa: result = b << sa;
			mips_pkg::alu_srl_sa: result = b >> sa;
			mips_pkg::alu_sra_sa: result = $unsigned($signed(b) >>> sa);

			// shift amount from rs
			mips_pkg::alu_sll: result = b << a[4:0];
			mips_pkg::alu_srl: result = b >> a[4:0];
			mips_pkg::alu_sra: result = $unsigned($signed(b) >>> a[4:0]);

			// b already holds imm << 16
			mips_pkg::alu_lui: result = b;
			mips_pkg::alu_clo: result = lead_zeros(~a);
			mips_pkg::alu_clz: result = lead_zeros(a);
			mips_pkg::alu_sc:  result = 32'd1;

			mips_pkg::alu_teq:  trap = (a == b);
			mips_pkg::alu_tne:  trap = (a != b);
			mips_pkg::alu_tge:  trap = !lt_signed;
			mips_pkg::alu_tgeu: trap = !lt_unsigned;
			mips_pkg::alu_tlt:  trap = lt_signed;
			mips_pkg::alu_tltu: trap = lt_unsigned;

			// data headed for hi/lo
			mips_pkg::alu_mthi: result = a;
			mips_pkg::alu_mtlo: result = a;

			// multiply/divide codes and donothing fall through to zero
			default: result = 32'd0;
		endcase
	end

endmodule

//--- alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
	input  logic [31:0]        instr,
	output mips_pkg::dec_ctl_t ctl
);

	logic [5:0] opcode;
	logic [4:0] rt;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign rt     = instr[20:16];
	assign funct  = instr[5:0];

	always_comb begin
		ctl.alu_op   = mips_pkg::alu_donothing;
		ctl.br_op    = mips_pkg::br_none;
		ctl.imm_kind = mips_pkg::imm_reg;
		ctl.sa       = instr[10:6];

		// alu operation
		case (opcode)
			mips_pkg::op_r_type: begin
				case (funct)
					mips_pkg::fn_and:   ctl.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:    ctl.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor:   ctl.alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_nor:   ctl.alu_op = mips_pkg::alu_nor;
					mips_pkg::fn_add:   ctl.alu_op = mips_pkg::alu_add;
					mips_pkg::fn_addu:  ctl.alu_op = mips_pkg::alu_addu;
					mips_pkg::fn_sub:   ctl.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_subu:  ctl.alu_op = mips_pkg::alu_subu;
					mips_pkg::fn_slt:   ctl.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu:  ctl.alu_op = mips_pkg::alu_sltu;
					mips_pkg::fn_div:   ctl.alu_op = mips_pkg::alu_signed_div;
					mips_pkg::fn_divu:  ctl.alu_op = mips_pkg::alu_unsigned_div;
					mips_pkg::fn_mult:  ctl.alu_op = mips_pkg::alu_signed_mult;
					mips_pkg::fn_multu: ctl.alu_op = mips_pkg::alu_unsigned_mult;
					mips_pkg::fn_sll:   ctl.alu_op = mips_pkg::alu_sll_sa;
					mips_pkg::fn_srl:   ctl.alu_op = mips_pkg::alu_srl_sa;
					mips_pkg::fn_sra:   ctl.alu_op = mips_pkg::alu_sra_sa;
					mips_pkg::fn_sllv:  ctl.alu_op = mips_pkg::alu_sll;
					mips_pkg::fn_srlv:  ctl.alu_op = mips_pkg::alu_srl;
					mips_pkg::fn_srav:  ctl.alu_op = mips_pkg::alu_sra;
					mips_pkg::fn_mthi:  ctl.alu_op = mips_pkg::alu_mthi;
					mips_pkg::fn_mtlo:  ctl.alu_op = mips_pkg::alu_mtlo;
					mips_pkg::fn_teq:   ctl.alu_op = mips_pkg::alu_teq;
					mips_pkg::fn_tne:   ctl.alu_op = mips_pkg::alu_tne;
					mips_pkg::fn_tge:   ctl.alu_op = mips_pkg::alu_tge;
					mips_pkg::fn_tgeu:  ctl.alu_op = mips_pkg::alu_tgeu;
					mips_pkg::fn_tlt:   ctl.alu_op = mips_pkg::alu_tlt;
					mips_pkg::fn_tltu:  ctl.alu_op = mips_pkg::alu_tltu;
					default:            ctl.alu_op = mips_pkg::alu_donothing;
				endcase
			end
			mips_pkg::op_addi:  ctl.alu_op = mips_pkg::alu_add;
			mips_pkg::op_addiu: ctl.alu_op = mips_pkg::alu_addu;
			mips_pkg::op_slti:  ctl.alu_op = mips_pkg::alu_slt;
			mips_pkg::op_sltiu: ctl.alu_op = mips_pkg::alu_sltu;
			mips_pkg::op_andi:  ctl.alu_op = mips_pkg::alu_and;
			mips_pkg::op_ori:   ctl.alu_op = mips_pkg::alu_or;
			mips_pkg::op_xori:  ctl.alu_op = mips_pkg::alu_xor;
			mips_pkg::op_lui:   ctl.alu_op = mips_pkg::alu_lui;
			mips_pkg::op_sc:    ctl.alu_op = mips_pkg::alu_sc;
			mips_pkg::op_special2: begin
				case (funct)
					mips_pkg::fn2_clo:   ctl.alu_op = mips_pkg::alu_clo;
					mips_pkg::fn2_clz:   ctl.alu_op = mips_pkg::alu_clz;
					mips_pkg::fn2_mul:   ctl.alu_op = mips_pkg::alu_signed_mult;
					mips_pkg::fn2_madd:  ctl.alu_op = mips_pkg::alu_madd;
					mips_pkg::fn2_maddu: ctl.alu_op = mips_pkg::alu_maddu;
					mips_pkg::fn2_msub:  ctl.alu_op = mips_pkg::alu_msub;
					mips_pkg::fn2_msubu: ctl.alu_op = mips_pkg::alu_msubu;
					default:             ctl.alu_op = mips_pkg::alu_donothing;
				endcase
			end
			// immediate traps live under regimm
			mips_pkg::op_regimm: begin
				case (rt)
					mips_pkg::rt_teqi:  ctl.alu_op = mips_pkg::alu_teq;
					mips_pkg::rt_tnei:  ctl.alu_op = mips_pkg::alu_tne;
					mips_pkg::rt_tgei:  ctl.alu_op = mips_pkg::alu_tge;
					mips_pkg::rt_tgeiu: ctl.alu_op = mips_pkg::alu_tgeu;
					mips_pkg::rt_tlti:  ctl.alu_op = mips_pkg::alu_tlt;
					mips_pkg::rt_tltiu: ctl.alu_op = mips_pkg::alu_tltu;
					default:            ctl.alu_op = mips_pkg::alu_donothing;
				endcase
			end
			default: ctl.alu_op = mips_pkg::alu_donothing;
		endcase

		// branch compare
		case (opcode)
			mips_pkg::op_beq:  ctl.br_op = mips_pkg::br_eq;
			mips_pkg::op_bne:  ctl.br_op = mips_pkg::br_neq;
			mips_pkg::op_bgtz: ctl.br_op = mips_pkg::br_gtz;
			mips_pkg::op_blez: ctl.br_op = mips_pkg::br_lez;
			mips_pkg::op_regimm: begin
				if (rt == mips_pkg::rt_bltz || rt == mips_pkg::rt_bltzal)
					ctl.br_op = mips_pkg::br_ltz;
				else if (rt == mips_pkg::rt_bgez || rt == mips_pkg::rt_bgezal)
					ctl.br_op = mips_pkg::br_gez;
			end
			default: ctl.br_op = mips_pkg::br_none;
		endcase

		// operand b source
		case (opcode)
			mips_pkg::op_addi, mips_pkg::op_addiu,
			mips_pkg::op_slti, mips_pkg::op_sltiu: ctl.imm_kind = mips_pkg::imm_sign;
			mips_pkg::op_andi, mips_pkg::op_ori,
			mips_pkg::op_xori:                     ctl.imm_kind = mips_pkg::imm_zero;
			mips_pkg::op_lui:                      ctl.imm_kind = mips_pkg::imm_upper;
			mips_pkg::op_regimm: begin
				// tgeiu/tltiu still sign extend, then compare unsigned
				if (rt inside {mips_pkg::rt_teqi, mips_pkg::rt_tnei, mips_pkg::rt_tgei,
						mips_pkg::rt_tgeiu, mips_pkg::rt_tlti, mips_pkg::rt_tltiu})
					ctl.imm_kind = mips_pkg::imm_sign;
			end
			default: ctl.imm_kind = mips_pkg::imm_reg;
		endcase
	end

endmodule

//--- mips_pkg.sv
package mips_pkg;

	// alu operation codes
	typedef enum logic [5:0] {
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_add,
		alu_addu,
		alu_sub,
		alu_subu,
		alu_slt,
		alu_sltu,
		alu_sll_sa,
		alu_srl_sa,
		alu_sra_sa,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui,
		alu_clo,
		alu_clz,
		alu_sc,
		alu_teq,
		alu_tne,
		alu_tge,
		alu_tgeu,
		alu_tlt,
		alu_tltu,
		alu_mthi,
		alu_mtlo,
		alu_signed_mult,
		alu_unsigned_mult,
		alu_signed_div,
		alu_unsigned_div,
		alu_madd,
		alu_maddu,
		alu_msub,
		alu_msubu,
		alu_donothing
	} alu_op_e;

	// branch compare codes
	typedef enum logic [2:0] {
		br_none,
		br_eq,
		br_neq,
		br_gtz,
		br_lez,
		br_ltz,
		br_gez
	} br_op_e;

	// source of operand b
	typedef enum logic [1:0] {
		imm_reg,
		imm_sign,
		imm_zero,
		imm_upper
	} imm_kind_e;

	// major opcodes
	localparam logic [5:0] op_r_type   = 6'b000000;
	localparam logic [5:0] op_regimm   = 6'b000001;
	localparam logic [5:0] op_beq      = 6'b000100;
	localparam logic [5:0] op_bne      = 6'b000101;
	localparam logic [5:0] op_blez     = 6'b000110;
	localparam logic [5:0] op_bgtz     = 6'b000111;
	localparam logic [5:0] op_addi     = 6'b001000;
	localparam logic [5:0] op_addiu    = 6'b001001;
	localparam logic [5:0] op_slti     = 6'b001010;
	localparam logic [5:0] op_sltiu    = 6'b001011;
	localparam logic [5:0] op_andi     = 6'b001100;
	localparam logic [5:0] op_ori      = 6'b001101;
	localparam logic [5:0] op_xori     = 6'b001110;
	localparam logic [5:0] op_lui      = 6'b001111;
	localparam logic [5:0] op_special2 = 6'b011100;
	localparam logic [5:0] op_sc       = 6'b111000;

	// r-type function field
	localparam logic [5:0] fn_sll   = 6'b000000;
	localparam logic [5:0] fn_srl   = 6'b000010;
	localparam logic [5:0] fn_sra   = 6'b000011;
	localparam logic [5:0] fn_sllv  = 6'b000100;
	localparam logic [5:0] fn_srlv  = 6'b000110;
	localparam logic [5:0] fn_srav  = 6'b000111;
	localparam logic [5:0] fn_mthi  = 6'b010001;
	localparam logic [5:0] fn_mtlo  = 6'b010011;
	localparam logic [5:0] fn_mult  = 6'b011000;
	localparam logic [5:0] fn_multu = 6'b011001;
	localparam logic [5:0] fn_div   = 6'b011010;
	localparam logic [5:0] fn_divu  = 6'b011011;
	localparam logic [5:0] fn_add   = 6'b100000;
	localparam logic [5:0] fn_addu  = 6'b100001;
	localparam logic [5:0] fn_sub   = 6'b100010;
	localparam logic [5:0] fn_subu  = 6'b100011;
	localparam logic [5:0] fn_and   = 6'b100100;
	localparam logic [5:0] fn_or    = 6'b100101;
	localparam logic [5:0] fn_xor   = 6'b100110;
	localparam logic [5:0] fn_nor   = 6'b100111;
	localparam logic [5:0] fn_slt   = 6'b101010;
	localparam logic [5:0] fn_sltu  = 6'b101011;
	localparam logic [5:0] fn_tge   = 6'b110000;
	localparam logic [5:0] fn_tgeu  = 6'b110001;
	localparam logic [5:0] fn_tlt   = 6'b110010;
	localparam logic [5:0] fn_tltu  = 6'b110011;
	localparam logic [5:0] fn_teq   = 6'b110100;
	localparam logic [5:0] fn_tne   = 6'b110110;

	// special2 function field
	localparam logic [5:0] fn2_madd  = 6'b000000;
	localparam logic [5:0] fn2_maddu = 6'b000001;
	localparam logic [5:0] fn2_mul   = 6'b000010;
	localparam logic [5:0] fn2_msub  = 6'b000100;
	localparam logic [5:0] fn2_msubu = 6'b000101;
	localparam logic [5:0] fn2_clz   = 6'b100000;
	localparam logic [5:0] fn2_clo   = 6'b100001;

	// regimm rt field
	localparam logic [4:0] rt_bltz   = 5'b00000;
	localparam logic [4:0] rt_bgez   = 5'b00001;
	localparam logic [4:0] rt_tgei   = 5'b01000;
	localparam logic [4:0] rt_tgeiu  = 5'b01001;
	localparam logic [4:0] rt_tlti   = 5'b01010;
	localparam logic [4:0] rt_tltiu  = 5'b01011;
	localparam logic [4:0] rt_teqi   = 5'b01100;
	localparam logic [4:0] rt_tnei   = 5'b01110;
	localparam logic [4:0] rt_bltzal = 5'b10000;
	localparam logic [4:0] rt_bgezal = 5'b10001;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] rs_value;
		logic [31:0] rt_value;
	} exec_req_t;

	typedef struct packed {
		alu_op_e     alu_op;
		br_op_e      br_op;
		imm_kind_e   imm_kind;
		logic [4:0]  sa;
	} dec_ctl_t;

	typedef struct packed {
		logic [31:0] result;
		logic        overflow;
		logic        trap;
		logic        branch_taken;
	} exec_rsp_t;

endpackage
